/* src/timer_pkg.sv */
package timer_pkg;

    // bus widths.
    localparam int axil_addr_w = 12;
    localparam int data_w      = 32;
    localparam int strb_w      = data_w / 8;
    localparam int ctrl_addr_w = 10;

    // word addresses on the control bus.
    localparam logic [ctrl_addr_w-1:0] reg_ctrl   = 10'd0;
    localparam logic [ctrl_addr_w-1:0] reg_load   = 10'd1;
    localparam logic [ctrl_addr_w-1:0] reg_count  = 10'd2;
    localparam logic [ctrl_addr_w-1:0] reg_status = 10'd3;

    // control and status bit positions.
    localparam int ctrl_en_bit        = 0;
    localparam int ctrl_periodic_bit  = 1;
    localparam int ctrl_irq_en_bit    = 2;
    localparam int status_expired_bit = 0;

    localparam logic [1:0] resp_okay = 2'b00;

    // bridge state encodings.
    localparam logic [1:0] w_st_aw    = 2'd0;
    localparam logic [1:0] w_st_w     = 2'd1;
    localparam logic [1:0] w_st_write = 2'd2;
    localparam logic [1:0] w_st_b     = 2'd3;
    localparam logic [1:0] r_st_ar    = 2'd0;
    localparam logic [1:0] r_st_read  = 2'd1;
    localparam logic [1:0] r_st_r     = 2'd2;

endpackage

/* src/axil_ctrl_bridge.sv */
`timescale 1ns/1ps

module axil_ctrl_bridge (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              s_axil_awvalid,
    output logic                              s_axil_awready,
    input  logic [timer_pkg::axil_addr_w-1:0] s_axil_awaddr,

    input  logic                              s_axil_wvalid,
    output logic                              s_axil_wready,
    input  logic [timer_pkg::data_w-1:0]      s_axil_wdata,
    input  logic [timer_pkg::strb_w-1:0]      s_axil_wstrb,

    output logic                              s_axil_bvalid,
    input  logic                              s_axil_bready,
    output logic [1:0]                        s_axil_bresp,

    input  logic                              s_axil_arvalid,
    output logic                              s_axil_arready,
    input  logic [timer_pkg::axil_addr_w-1:0] s_axil_araddr,

    output logic                              s_axil_rvalid,
    input  logic                              s_axil_rready,
    output logic [timer_pkg::data_w-1:0]      s_axil_rdata,
    output logic [1:0]                        s_axil_rresp,

    output logic                              ctrl_wen,
    output logic [timer_pkg::ctrl_addr_w-1:0] ctrl_waddr,
    output logic [timer_pkg::data_w-1:0]      ctrl_wdata,
    output logic                              ctrl_ren,
    output logic [timer_pkg::ctrl_addr_w-1:0] ctrl_raddr,
    input  logic [timer_pkg::data_w-1:0]      ctrl_rdata
);
    import timer_pkg::*;

    logic [1:0]        w_state;
    logic [1:0]        w_state_next;
    logic [1:0]        r_state;
    logic [1:0]        r_state_next;
    logic [data_w-1:0] wstrb_bits;
    logic [data_w-1:0] read_data;

    // write side steps through address, data, one write cycle and the response.
    always_ff @(posedge clk) begin
        if (rst) begin
            w_state <= w_st_aw;
        end else begin
            w_state <= w_state_next;
        end
    end

    always_comb begin
        case (w_state)
            w_st_aw:    w_state_next = s_axil_awvalid ? w_st_w : w_st_aw;
            w_st_w:     w_state_next = s_axil_wvalid ? w_st_write : w_st_w;
            w_st_write: w_state_next = w_st_b;
            w_st_b:     w_state_next = s_axil_bready ? w_st_aw : w_st_b;
            default:    w_state_next = w_st_aw;
        endcase
    end

    always_ff @(posedge clk) begin
        if (s_axil_awvalid && s_axil_awready) begin
            ctrl_waddr <= s_axil_awaddr[axil_addr_w-1:2];
        end
    end

    // each strobe bit covers one byte lane.
    always_comb begin
        for (int i = 0; i < strb_w; i++) begin
            wstrb_bits[i*8 +: 8] = {8{s_axil_wstrb[i]}};
        end
    end

    // unstrobed bytes land as zero.
    always_ff @(posedge clk) begin
        if (s_axil_wvalid && s_axil_wready) begin
            ctrl_wdata <= s_axil_wdata & wstrb_bits;
        end
    end

    assign ctrl_wen       = (w_state == w_st_write);
    assign s_axil_awready = (w_state == w_st_aw);
    assign s_axil_wready  = (w_state == w_st_w);
    assign s_axil_bvalid  = (w_state == w_st_b);
    assign s_axil_bresp   = resp_okay;

    // read side runs on its own.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= r_st_ar;
        end else begin
            r_state <= r_state_next;
        end
    end

    always_comb begin
        case (r_state)
            r_st_ar:   r_state_next = s_axil_arvalid ? r_st_read : r_st_ar;
            r_st_read: r_state_next = r_st_r;
            r_st_r:    r_state_next = s_axil_rready ? r_st_ar : r_st_r;
            default:   r_state_next = r_st_ar;
        endcase
    end

    always_ff @(posedge clk) begin
        if (s_axil_arvalid && s_axil_arready) begin
            ctrl_raddr <= s_axil_araddr[axil_addr_w-1:2];
        end
    end

    // hold the returned word until the master takes it.
    always_ff @(posedge clk) begin
        if (r_state == r_st_read) begin
            read_data <= ctrl_rdata;
        end
    end

    assign ctrl_ren       = (r_state == r_st_read);
    assign s_axil_arready = (r_state == r_st_ar);
    assign s_axil_rvalid  = (r_state == r_st_r);
    assign s_axil_rdata   = read_data;
    assign s_axil_rresp   = resp_okay;

endmodule

/* src/timer_regs.sv */
`timescale 1ns/1ps

module timer_regs (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              ctrl_wen,
    input  logic [timer_pkg::ctrl_addr_w-1:0] ctrl_waddr,
    input  logic [timer_pkg::data_w-1:0]      ctrl_wdata,
    input  logic                              ctrl_ren,
    input  logic [timer_pkg::ctrl_addr_w-1:0] ctrl_raddr,
    output logic [timer_pkg::data_w-1:0]      ctrl_rdata,

    output logic                              enable,
    output logic                              periodic,
    output logic [timer_pkg::data_w-1:0]      load_value,
    output logic                              load,
    input  logic [timer_pkg::data_w-1:0]      count,
    input  logic                              expired,
    output logic                              irq
);
    import timer_pkg::*;

    logic [2:0] ctrl_q;
    logic       expired_q;
    logic       load_wr_d;
    logic       enable_d;
    logic       status_clr;

    assign status_clr = ctrl_wen && (ctrl_waddr == reg_status) &&
                        ctrl_wdata[status_expired_bit];

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q     <= '0;
            load_value <= '0;
            expired_q  <= 1'b0;
            load_wr_d  <= 1'b0;
            enable_d   <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (ctrl_wen && (ctrl_waddr == reg_ctrl)) begin
                ctrl_q <= ctrl_wdata[2:0];
            end
            if (ctrl_wen && (ctrl_waddr == reg_load)) begin
                load_value <= ctrl_wdata;
            end
            // a fresh expiry beats a clear in the same cycle.
            expired_q <= expired | (expired_q & ~status_clr);
            load_wr_d <= ctrl_wen && (ctrl_waddr == reg_load);
            enable_d  <= ctrl_q[ctrl_en_bit];
            irq       <= expired_q & ctrl_q[ctrl_irq_en_bit];
        end
    end

    assign enable   = ctrl_q[ctrl_en_bit];
    assign periodic = ctrl_q[ctrl_periodic_bit];

    // reload after a new load word or when the timer is switched on.
    assign load = load_wr_d | (enable & ~enable_d);

    always_comb begin
        ctrl_rdata = '0;
        if (ctrl_ren) begin
            case (ctrl_raddr)
                reg_ctrl:   ctrl_rdata[2:0] = ctrl_q;
                reg_load:   ctrl_rdata = load_value;
                reg_count:  ctrl_rdata = count;
                reg_status: ctrl_rdata[status_expired_bit] = expired_q;
                default:    ctrl_rdata = '0;
            endcase
        end
    end

endmodule

/* src/timer_counter.sv */
`timescale 1ns/1ps

module timer_counter (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         enable,
    input  logic                         periodic,
    input  logic                         load,
    input  logic [timer_pkg::data_w-1:0] load_value,

    output logic [timer_pkg::data_w-1:0] count,
    output logic                         expired
);
    import timer_pkg::*;

    logic last_tick;

    // the step that takes the count from one to zero.
    assign last_tick = enable && !load && (count == data_w'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            expired <= 1'b0;
        end else begin
            expired <= last_tick;
            if (load) begin
                count <= load_value;
            end else if (last_tick) begin
                // periodic mode starts the next period right away.
                count <= periodic ? load_value : '0;
            end else if (enable && (count != '0)) begin
                count <= count - data_w'(1);
            end
        end
    end

endmodule

/* src/timer_top.sv */
`timescale 1ns/1ps

module timer_top (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              s_axil_awvalid,
    output logic                              s_axil_awready,
    input  logic [timer_pkg::axil_addr_w-1:0] s_axil_awaddr,
    input  logic                              s_axil_wvalid,
    output logic                              s_axil_wready,
    input  logic [timer_pkg::data_w-1:0]      s_axil_wdata,
    input  logic [timer_pkg::strb_w-1:0]      s_axil_wstrb,
    output logic                              s_axil_bvalid,
    input  logic                              s_axil_bready,
    output logic [1:0]                        s_axil_bresp,
    input  logic                              s_axil_arvalid,
    output logic                              s_axil_arready,
    input  logic [timer_pkg::axil_addr_w-1:0] s_axil_araddr,
    output logic                              s_axil_rvalid,
    input  logic                              s_axil_rready,
    output logic [timer_pkg::data_w-1:0]      s_axil_rdata,
    output logic [1:0]                        s_axil_rresp,

    output logic                              irq
);
    import timer_pkg::*;

    logic                   ctrl_wen;
    logic [ctrl_addr_w-1:0] ctrl_waddr;
    logic [data_w-1:0]      ctrl_wdata;
    logic                   ctrl_ren;
    logic [ctrl_addr_w-1:0] ctrl_raddr;
    logic [data_w-1:0]      ctrl_rdata;
    logic                   enable;
    logic                   periodic;
    logic                   load;
    logic [data_w-1:0]      load_value;
    logic [data_w-1:0]      count;
    logic                   expired;

    axil_ctrl_bridge i_axil_ctrl_bridge (.*);

    timer_regs i_timer_regs (.*);

    timer_counter i_timer_counter (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .periodic   (periodic),
        .load       (load),
        .load_value (load_value),
        .count      (count),
        .expired    (expired)
    );

endmodule

/* tb/timer_checker.sv */
`timescale 1ns/1ps

module timer_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              s_axil_awvalid,
    input logic                              s_axil_awready,
    input logic [timer_pkg::axil_addr_w-1:0] s_axil_awaddr,
    input logic                              s_axil_wvalid,
    input logic                              s_axil_wready,
    input logic [timer_pkg::data_w-1:0]      s_axil_wdata,
    input logic [timer_pkg::strb_w-1:0]      s_axil_wstrb,
    input logic                              s_axil_bvalid,
    input logic                              s_axil_bready,
    input logic [1:0]                        s_axil_bresp,
    input logic                              s_axil_arvalid,
    input logic                              s_axil_arready,
    input logic [timer_pkg::axil_addr_w-1:0] s_axil_araddr,
    input logic                              s_axil_rvalid,
    input logic                              s_axil_rready,
    input logic [timer_pkg::data_w-1:0]      s_axil_rdata,
    input logic [1:0]                        s_axil_rresp,
    input logic                              irq
);
    import timer_pkg::*;

    int                     errors = 0;
    logic [data_w-1:0]      m_ctrl;
    logic [data_w-1:0]      m_load;
    logic [ctrl_addr_w-1:0] waddr_q;
    logic [ctrl_addr_w-1:0] raddr_q;
    logic [1:0]             ar_d;
    logic [1:0]             w_d;
    logic                   rvalid_q;
    logic                   rready_q;
    logic                   bvalid_q;
    logic                   bready_q;
    logic [data_w-1:0]      rdata_q;
    logic [1:0]             bresp_q;
    logic [1:0]             irq_en_d;

    // one byte lane per strobe bit.
    function automatic logic [data_w-1:0] strobe_mask(input logic [strb_w-1:0] strb);
        logic [data_w-1:0] m;
        for (int i = 0; i < strb_w; i++) begin
            m[i*8 +: 8] = {8{strb[i]}};
        end
        return m;
    endfunction

    task automatic expect_value(input string what, input logic [data_w-1:0] got,
                                input logic [data_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic expect_at_most(input string what, input logic [data_w-1:0] got,
                                  input logic [data_w-1:0] limit);
        if (got > limit) begin
            errors++;
            $display("mismatch at %0d ns: %s is 0x%08h, above 0x%08h", $time, what, got, limit);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_ctrl   <= '0;
            m_load   <= '0;
            ar_d     <= '0;
            w_d      <= '0;
            rvalid_q <= 1'b0;
            rready_q <= 1'b0;
            bvalid_q <= 1'b0;
            bready_q <= 1'b0;
            irq_en_d <= '0;
        end else begin
            ar_d     <= {ar_d[0], s_axil_arvalid & s_axil_arready};
            w_d      <= {w_d[0], s_axil_wvalid & s_axil_wready};
            rvalid_q <= s_axil_rvalid;
            rready_q <= s_axil_rready;
            bvalid_q <= s_axil_bvalid;
            bready_q <= s_axil_bready;
            rdata_q  <= s_axil_rdata;
            bresp_q  <= s_axil_bresp;
            irq_en_d <= {irq_en_d[0], m_ctrl[ctrl_irq_en_bit]};
            if (s_axil_awvalid && s_axil_awready) begin
                waddr_q <= s_axil_awaddr[axil_addr_w-1:2];
            end
            if (s_axil_arvalid && s_axil_arready) begin
                raddr_q <= s_axil_araddr[axil_addr_w-1:2];
            end
            if (s_axil_wvalid && s_axil_wready && waddr_q == reg_ctrl) begin
                m_ctrl <= s_axil_wdata & strobe_mask(s_axil_wstrb);
            end
            if (s_axil_wvalid && s_axil_wready && waddr_q == reg_load) begin
                m_load <= s_axil_wdata & strobe_mask(s_axil_wstrb);
            end
            if ((s_axil_rvalid && !rvalid_q) != ar_d[1]) begin
                report_error("rvalid did not rise two cycles after the AR handshake");
            end
            if ((s_axil_bvalid && !bvalid_q) != w_d[1]) begin
                report_error("bvalid did not rise two cycles after the W handshake");
            end
            if (rvalid_q && !rready_q && (!s_axil_rvalid || s_axil_rdata !== rdata_q)) begin
                report_error("read response changed while rready was low");
            end
            if (bvalid_q && !bready_q && (!s_axil_bvalid || s_axil_bresp !== bresp_q)) begin
                report_error("write response changed while bready was low");
            end
            // irq follows a control write two cycles after the W handshake.
            if (irq && !irq_en_d[1]) begin
                report_error("irq is high while interrupt enable is off");
            end
            if (s_axil_bvalid && s_axil_bready) begin
                expect_value("bresp", s_axil_bresp, resp_okay);
            end
            if (s_axil_rvalid && s_axil_rready) begin
                expect_value("rresp", s_axil_rresp, resp_okay);
                // count and status depend on the timer and are checked by the test.
                case (raddr_q)
                    reg_ctrl:   expect_value("control read", s_axil_rdata, m_ctrl & 32'h7);
                    reg_load:   expect_value("load read", s_axil_rdata, m_load);
                    reg_count:  ;
                    reg_status: ;
                    default:    expect_value("unmapped read", s_axil_rdata, '0);
                endcase
            end
        end
    end

endmodule

/* tb/tb_timer_top.sv */
`timescale 1ns/1ps

module tb_timer_top;
    import timer_pkg::*;

    localparam int wait_limit = 64;
    localparam int irq_margin = 16;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   s_axil_awvalid;
    logic                   s_axil_awready;
    logic [axil_addr_w-1:0] s_axil_awaddr;
    logic                   s_axil_wvalid;
    logic                   s_axil_wready;
    logic [data_w-1:0]      s_axil_wdata;
    logic [strb_w-1:0]      s_axil_wstrb;
    logic                   s_axil_bvalid;
    logic                   s_axil_bready;
    logic [1:0]             s_axil_bresp;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    logic [axil_addr_w-1:0] s_axil_araddr;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;
    logic [data_w-1:0]      s_axil_rdata;
    logic [1:0]             s_axil_rresp;
    logic                   irq;
    logic [15:0]            lfsr = 16'd64222;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    int                     test_num = 0;
    int                     errors_at_start = 0;

    always #2 clk = ~clk;

    timer_top i_timer_top (.*);

    timer_checker scoreboard (.*);

    // fibonacci lfsr with taps 16, 14, 13 and 11 that steps once per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic stall(input string what);
        $display("timeout at %0d ns: %s", $time, what);
        $display("** FAIL **");
        $finish;
    endtask

    // polls a DUT output at each rising edge.
    task automatic wait_high(input string name, input int limit);
        int   t;
        logic seen;
        t    = 0;
        seen = 1'b0;
        while (!seen && t < limit) begin
            @(posedge clk);
            t++;
            if (name == "awready") begin
                seen = s_axil_awready;
            end else if (name == "wready") begin
                seen = s_axil_wready;
            end else if (name == "bvalid") begin
                seen = s_axil_bvalid;
            end else if (name == "arready") begin
                seen = s_axil_arready;
            end else if (name == "rvalid") begin
                seen = s_axil_rvalid;
            end else begin
                seen = irq;
            end
        end
        if (!seen) begin
            stall({name, " did not go high in time"});
        end
    endtask

    task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [data_w-1:0] data,
                              input logic [strb_w-1:0] strb, input int hold);
        s_axil_awvalid <= 1'b1;
        s_axil_awaddr  <= addr;
        s_axil_wvalid  <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= strb;
        wait_high("awready", wait_limit);
        s_axil_awvalid <= 1'b0;
        wait_high("wready", wait_limit);
        s_axil_wvalid <= 1'b0;
        wait_high("bvalid", wait_limit);
        repeat (hold) @(posedge clk);
        s_axil_bready <= 1'b1;
        @(posedge clk);
        s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int hold,
                             output logic [data_w-1:0] data);
        s_axil_arvalid <= 1'b1;
        s_axil_araddr  <= addr;
        wait_high("arready", wait_limit);
        s_axil_arvalid <= 1'b0;
        wait_high("rvalid", wait_limit);
        repeat (hold) @(posedge clk);
        s_axil_rready <= 1'b1;
        @(posedge clk);
        data = s_axil_rdata;
        s_axil_rready <= 1'b0;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (scoreboard.errors == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", test_num, name);
        end
        errors_at_start = scoreboard.errors;
    endtask

    initial begin
        logic [data_w-1:0]      d;
        logic [ctrl_addr_w-1:0] word;
        int                     len;
        rst            = 1'b1;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_bready  = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr  = '0;
        s_axil_rready  = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        axil_read({reg_ctrl, 2'b00}, rand_bits(2), d);
        axil_read({reg_load, 2'b00}, rand_bits(2), d);
        axil_read({reg_count, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("count after reset", d, '0);
        axil_read({reg_status, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("status after reset", d, '0);
        word = 10'(4 + rand_bits(9));
        axil_read({word, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("irq after reset", irq, '0);
        end_test("reset values");

        for (int i = 0; i < 16; i++) begin
            case (rand_bits(2))
                0:       word = reg_ctrl;
                1:       word = reg_load;
                default: word = 10'(4 + rand_bits(9));
            endcase
            axil_write({word, 2'b00}, rand_bits(32), rand_bits(4), rand_bits(2));
            axil_read({word, 2'b00}, rand_bits(2), d);
        end
        end_test("register read back");

        // one-shot with interrupt enable is control value 5.
        axil_write({reg_ctrl, 2'b00}, '0, 4'hf, 0);
        axil_write({reg_status, 2'b00}, 32'h1, 4'hf, 0);
        len = 20 + rand_bits(4);
        axil_write({reg_load, 2'b00}, len, 4'hf, rand_bits(2));
        axil_write({reg_ctrl, 2'b00}, 32'h5, 4'hf, rand_bits(2));
        wait_high("irq", len + irq_margin);
        axil_read({reg_status, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("status after expiry", d, 32'h1);
        axil_read({reg_count, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("count after expiry", d, '0);
        end_test("one-shot expiry");

        axil_write({reg_status, 2'b00}, 32'h1, 4'hf, rand_bits(2));
        @(posedge clk);
        scoreboard.expect_value("irq after clear", irq, '0);
        for (int i = 0; i < 2 * len; i++) begin
            @(posedge clk);
            scoreboard.expect_value("one-shot irq after clear", irq, '0);
        end
        axil_read({reg_status, 2'b00}, rand_bits(2), d);
        scoreboard.expect_value("status after clear", d, '0);
        end_test("write-one-to-clear");

        // periodic with interrupt enable is control value 7.
        axil_write({reg_ctrl, 2'b00}, '0, 4'hf, 0);
        axil_write({reg_status, 2'b00}, 32'h1, 4'hf, 0);
        len = 20 + rand_bits(4);
        axil_write({reg_load, 2'b00}, len, 4'hf, 0);
        axil_write({reg_ctrl, 2'b00}, 32'h7, 4'hf, 0);
        for (int k = 0; k < 3; k++) begin
            wait_high("irq", len + irq_margin);
            axil_read({reg_count, 2'b00}, 0, d);
            scoreboard.expect_at_most("running count", d, len);
            axil_write({reg_status, 2'b00}, 32'h1, 4'hf, 0);
            @(posedge clk);
            scoreboard.expect_value("irq after periodic clear", irq, '0);
        end
        end_test("periodic reload");

        axil_write({reg_ctrl, 2'b00}, '0, 4'hf, 6);
        axil_write({reg_load, 2'b00}, rand_bits(32), 4'hf, 6);
        axil_read({reg_load, 2'b00}, 6, d);
        axil_read({reg_ctrl, 2'b00}, 0, d);
        axil_write({reg_load, 2'b00}, rand_bits(32), rand_bits(4), 0);
        axil_read({reg_load, 2'b00}, 0, d);
        end_test("back-pressure");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, scoreboard.errors);
        if (tests_failed == 0 && scoreboard.errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* flist.f */
src/timer_pkg.sv
src/axil_ctrl_bridge.sv
src/timer_regs.sv
src/timer_counter.sv
src/timer_top.sv
tb/timer_checker.sv
tb/tb_timer_top.sv

/* Bender.yml */
package:
  name: axil_timer

sources:
  - files:
      - src/timer_pkg.sv
      - src/axil_ctrl_bridge.sv
      - src/timer_regs.sv
      - src/timer_counter.sv
      - src/timer_top.sv
  - target: test
    files:
      - tb/timer_checker.sv
      - tb/tb_timer_top.sv
